// ==== sim.f ====
+incdir+design
design/diad_pkg.sv
design/diad_mem.sv
design/diad_regfile.sv
design/diad_fetch.sv
design/diad_decode.sv
design/diad_execute.sv
design/diad_memacc.sv
design/diad_writeback.sv
design/diad.sv
testbench/diad_asserts.sv
testbench/diad_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -f sim.f --top-module diad_tb -o diad_sim &&
./obj_dir/diad_sim | tee /dev/stderr | grep -q "TESTS PASSED" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== testbench/diad_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_tb import diad_pkg::*; ();

    localparam int PROG_LEN  = 64;
    localparam int DATA_BASE = 128;
    localparam int FIRST_RUN = 40; // The pause lands in the middle of the program
    localparam int PAUSE     = 10;
    localparam int TIMEOUT   = 400;
    localparam reg_idx_t BASE_REG = 3'd7;

    logic    iw_clk;
    logic    iw_rst;
    logic    run;
    logic    load_we;
    addr_t   load_addr;
    data_t   load_data;
    retire_t retire;

    data_t prog [PROG_LEN];
    data_t pre_data [PROG_LEN];
    logic  exp_we [PROG_LEN];
    data_t exp_wdata [PROG_LEN];
    int    retire_cnt [PROG_LEN];
    int    last_wr [8];
    int    value_errs = 0;
    int    order_errs = 0;
    int    count_errs = 0;
    int    retired_total = 0;
    int    next_pc = 0;
    int    cycles = 0;

    diad uut (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .run       (run),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .retire    (retire)
    );

    bind diad diad_asserts u_asserts (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .run    (run),
        .wr_en  (wr_en),
        .retire (retire)
    );

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    // A source is usable four slots after the instruction that writes it
    function automatic bit slot_ready(opcode_e op, reg_idx_t rd, reg_idx_t rs1,
                                      reg_idx_t rs2, int s);
        bit ok;
        ok = (s - last_wr[rs1]) >= 4;
        if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR}) begin
            ok = ok && ((s - last_wr[rs2]) >= 4);
        end
        if (op == OP_ST) begin
            ok = ok && ((s - last_wr[rd]) >= 4);
        end
        return ok;
    endfunction

    task automatic build_program();
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     f;
        for (int r = 0; r < 8; r++) begin
            last_wr[r] = -100;
        end
        for (int s = 0; s < PROG_LEN; s++) begin
            rd  = reg_idx_t'($urandom_range(6, 0)); // r7 stays the data base
            rs1 = reg_idx_t'($urandom_range(6, 0));
            rs2 = reg_idx_t'($urandom_range(6, 0));
            op  = opcode_e'($urandom_range(10, 1));
            f   = {3'b000, rs2};
            if (s < 16 && (op == OP_LD || op == OP_ST)) begin
                op = OP_ADDI;
            end
            if (op == OP_ADDI) begin
                f = imm_t'($urandom);
            end
            else if (op == OP_LD || op == OP_ST) begin
                rs1 = BASE_REG;
                f   = imm_t'($urandom_range(15, 0)); // Narrow window so loads meet stores
            end
            if (!slot_ready(op, rd, rs1, rs2, s)) begin
                op = OP_NOP;
            end
            // Base register goes 16, 32, 64, 128 and is ready from slot 16
            if (s == 0) begin
                op  = OP_ADDI;
                rd  = BASE_REG;
                rs1 = '0;
                f   = 6'd16;
            end
            else if (s <= 12 && s % 4 == 0) begin
                op  = OP_SHL;
                rd  = BASE_REG;
                rs1 = BASE_REG;
            end
            if (op != OP_NOP && op != OP_ST && rd != '0) begin
                last_wr[rd] = s;
            end
            prog[s] = {op, rd, rs1, f};
        end
    endtask

    // Sequential ISA model, one instruction at a time
    task automatic run_model();
        data_t    regs [8];
        data_t    dmem [256];
        opcode_e  op;
        reg_idx_t rd;
        data_t    a;
        data_t    b;
        data_t    sx;
        addr_t    ea;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (i >= DATA_BASE && i < DATA_BASE + PROG_LEN) ? pre_data[i - DATA_BASE] : '0;
        end
        for (int s = 0; s < PROG_LEN; s++) begin
            op = opcode_e'(prog[s][15:12]);
            rd = prog[s][11:9];
            a  = regs[prog[s][8:6]];
            b  = regs[prog[s][2:0]];
            sx = {{10{prog[s][5]}}, prog[s][5:0]};
            ea = addr_t'(a + sx);
            exp_we[s] = !(op inside {OP_NOP, OP_ST}) && rd != '0;
            case (op)
                OP_ADD:  exp_wdata[s] = a + b;
                OP_SUB:  exp_wdata[s] = a - b;
                OP_AND:  exp_wdata[s] = a & b;
                OP_OR:   exp_wdata[s] = a | b;
                OP_XOR:  exp_wdata[s] = a ^ b;
                OP_SHL:  exp_wdata[s] = {a[14:0], 1'b0};
                OP_SHR:  exp_wdata[s] = {1'b0, a[15:1]};
                OP_ADDI: exp_wdata[s] = a + sx;
                OP_LD:   exp_wdata[s] = dmem[ea];
                default: exp_wdata[s] = '0;
            endcase
            if (op == OP_ST) begin
                dmem[ea] = regs[rd];
            end
            if (exp_we[s]) begin
                regs[rd] = exp_wdata[s]; // r0 is never written so it reads as zero
            end
        end
    endtask

    task automatic write_word(addr_t a, data_t d);
        @(posedge iw_clk);
        load_we   <= 1'b1;
        load_addr <= a;
        load_data <= d;
    endtask

    task automatic compare_field(string name, int pc, data_t got, data_t exp);
        assert (got == exp) else begin
            value_errs++;
            $display("[ERROR] %0t pc %0d %s got 0x%04h expected 0x%04h",
                     $time, pc, name, got, exp);
        end
    endtask

    task automatic check_retire();
        int p;
        p = int'(retire.pc);
        assert (p == next_pc) else begin
            order_errs++;
            $display("[ERROR] %0t retire.pc got %0d expected %0d", $time, p, next_pc);
        end
        next_pc = p + 1;
        retired_total++;
        if (p < PROG_LEN) begin
            retire_cnt[p]++;
            compare_field("retire.opcode", p, data_t'(retire.opcode), data_t'(prog[p][15:12]));
            compare_field("retire.rd", p, data_t'(retire.rd), data_t'(prog[p][11:9]));
            compare_field("retire.we", p, data_t'(retire.we), data_t'(exp_we[p]));
            if (exp_we[p]) begin
                compare_field("retire.wdata", p, retire.wdata, exp_wdata[p]);
            end
        end
    endtask

    always @(negedge iw_clk) begin
        if (!iw_rst && retire.valid) begin
            check_retire();
        end
    end

    always @(posedge iw_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired_total, PROG_LEN);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int proto_errs;
        void'($urandom(32'hc14874d6));
        iw_rst    = 1'b1;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            pre_data[i] = data_t'($urandom);
        end
        run_model();
        repeat (16) @(posedge iw_clk);
        iw_rst <= 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            write_word(addr_t'(i), prog[i]);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            write_word(addr_t'(DATA_BASE + i), pre_data[i]);
        end
        @(posedge iw_clk);
        load_we <= 1'b0;
        run     <= 1'b1;
        repeat (FIRST_RUN) @(posedge iw_clk);
        run <= 1'b0;
        repeat (PAUSE) @(posedge iw_clk);
        run <= 1'b1;
        repeat (PROG_LEN - FIRST_RUN) @(posedge iw_clk);
        run <= 1'b0;
        while (retired_total < PROG_LEN) @(posedge iw_clk);
        repeat (8) @(posedge iw_clk); // Longer than the pipeline, catches stray retires
        for (int p = 0; p < PROG_LEN; p++) begin
            assert (retire_cnt[p] == 1) else begin
                count_errs++;
                $display("pc %0d retired %0d times instead of once", p, retire_cnt[p]);
            end
        end
        assert (retired_total == PROG_LEN) else begin
            count_errs++;
            $display("%0d instructions retired for a %0d word program", retired_total, PROG_LEN);
        end
        proto_errs = uut.u_asserts.fail_cnt;
        $display("Error counts: value %0d, order %0d, retire count %0d, protocol %0d",
                 value_errs, order_errs, count_errs, proto_errs);
        if (value_errs + order_errs + count_errs + proto_errs == 0) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/diad_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_asserts import diad_pkg::*; (
    input  wire logic    iw_clk,
    input  wire logic    iw_rst,
    input  wire logic    run,
    input  wire logic    wr_en,
    input  wire retire_t retire
);

    int         fail_cnt = 0;
    logic [3:0] idle_cnt; // Cycles since run was last high, saturating

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            idle_cnt <= 4'd15; // Nothing has been issued yet
        end
        else if (run) begin
            idle_cnt <= '0;
        end
        else if (idle_cnt != 4'd15) begin
            idle_cnt <= idle_cnt + 4'd1;
        end
    end

    // The last issued slot retires six cycles after run drops
    a_quiet_idle: assert property (@(posedge iw_clk) disable iff (iw_rst)
        idle_cnt >= 4'd6 |-> !retire.valid && !retire.we)
        else begin
            $error("retire active six or more cycles after run went low");
            fail_cnt++;
        end

    a_no_rf_write_idle: assert property (@(posedge iw_clk) disable iff (iw_rst)
        idle_cnt >= 4'd6 |-> !wr_en)
        else begin
            $error("register file written while the pipeline is empty");
            fail_cnt++;
        end

    // Back-to-back retires come from back-to-back fetches
    a_pc_steps: assert property (@(posedge iw_clk) disable iff (iw_rst)
        retire.valid && $past(retire.valid) |-> retire.pc == $past(retire.pc) + addr_t'(1))
        else begin
            $error("consecutive retires without a pc step of one");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== design/diad.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad import diad_pkg::*; (
    input  wire logic  iw_clk,
    input  wire logic  iw_rst,
    input  wire logic  run,
    input  wire logic  load_we,
    input  wire addr_t load_addr,
    input  wire data_t load_data,
    output retire_t    retire
);

    addr_t    fetch_addr;
    data_t    fetch_data;
    addr_t    data_addr;
    logic     data_we;
    data_t    data_wdata;
    data_t    data_rdata;
    reg_idx_t rd_addr1;
    reg_idx_t rd_addr2;
    data_t    rd_data1;
    data_t    rd_data2;
    logic     wr_en;
    reg_idx_t wr_addr;
    data_t    wr_data;
    fetch_t   fetch_q;
    decode_t  dec_q;
    exec_t    ex_q;
    mem_t     mem_q;

    diad_mem u_mem (
        .iw_clk     (iw_clk),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (data_addr),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    diad_regfile u_regfile (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    diad_fetch u_fetch (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .run        (run),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .fetch_out  (fetch_q)
    );

    diad_decode u_decode (.iw_clk(iw_clk), .iw_rst(iw_rst), .fetch_in(fetch_q), .dec_out(dec_q));

    diad_execute u_execute (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .dec_in   (dec_q),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .ex_out   (ex_q)
    );

    diad_memacc u_memacc (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .ex_in      (ex_q),
        .data_addr  (data_addr),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .mem_out    (mem_q)
    );

    diad_writeback u_writeback (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .mem_in  (mem_q),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .retire  (retire)
    );

endmodule

`default_nettype wire

// ==== design/diad_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_writeback import diad_pkg::*; (
    input  wire logic  iw_clk,
    input  wire logic  iw_rst,
    input  wire mem_t  mem_in,
    output logic       wr_en,
    output reg_idx_t   wr_addr,
    output data_t      wr_data,
    output retire_t    retire
);

    function automatic logic writes_reg(opcode_e op);
        return (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                           OP_SHL, OP_SHR, OP_ADDI, OP_LD});
    endfunction

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire.valid <= 1'b0;
            retire.we    <= 1'b0;
        end
        else begin
            retire.valid  <= mem_in.valid;
            retire.pc     <= mem_in.pc;
            retire.opcode <= mem_in.opcode;
            retire.rd     <= mem_in.rd;
            retire.we     <= mem_in.valid && writes_reg(mem_in.opcode) && (mem_in.rd != '0);
            retire.wdata  <= mem_in.result;
        end
    end

    // Register write lands at the edge ending the retire cycle
    assign wr_en   = retire.we;
    assign wr_addr = retire.rd;
    assign wr_data = retire.wdata;

endmodule

`default_nettype wire

// ==== design/diad_memacc.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_memacc import diad_pkg::*; (
    input  wire logic  iw_clk,
    input  wire logic  iw_rst,
    input  wire exec_t ex_in,
    output addr_t      data_addr,
    output logic       data_we,
    output data_t      data_wdata,
    input  wire data_t data_rdata,
    output mem_t       mem_out
);

    mem_t ma_q; // Record in the memory output stage

    // Memory address stage drives the data port straight from execute
    assign data_addr  = addr_t'(ex_in.result);
    assign data_we    = ex_in.valid && (ex_in.opcode == OP_ST);
    assign data_wdata = ex_in.sdata;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ma_q.valid <= 1'b0;
        end
        else begin
            ma_q.valid  <= ex_in.valid;
            ma_q.pc     <= ex_in.pc;
            ma_q.opcode <= ex_in.opcode;
            ma_q.rd     <= ex_in.rd;
            ma_q.result <= ex_in.result;
        end
    end

    // Load data is valid one cycle after its address
    always_comb begin
        mem_out = ma_q;
        if (ma_q.opcode == OP_LD) begin
            mem_out.result = data_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/diad_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_execute import diad_pkg::*; (
    input  wire logic     iw_clk,
    input  wire logic     iw_rst,
    input  wire decode_t  dec_in,
    output reg_idx_t      rd_addr1,
    output reg_idx_t      rd_addr2,
    input  wire data_t    rd_data1,
    input  wire data_t    rd_data2,
    output exec_t         ex_out
);

    data_t result;

    // A store reads its data register through the second port
    assign rd_addr1 = dec_in.rs1;
    assign rd_addr2 = (dec_in.opcode == OP_ST) ? dec_in.rd : dec_in.rs2;

    always_comb begin
        result = '0;
        case (dec_in.opcode)
            OP_ADD:  result = rd_data1 + rd_data2;
            OP_SUB:  result = rd_data1 - rd_data2;
            OP_AND:  result = rd_data1 & rd_data2;
            OP_OR:   result = rd_data1 | rd_data2;
            OP_XOR:  result = rd_data1 ^ rd_data2;
            OP_SHL:  result = rd_data1 << 1;
            OP_SHR:  result = rd_data1 >> 1;
            OP_ADDI: result = rd_data1 + dec_in.imm;
            OP_LD,
            OP_ST:   result = rd_data1 + dec_in.imm; // Effective address
            default: result = '0;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ex_out.valid <= 1'b0;
        end
        else begin
            ex_out.valid  <= dec_in.valid;
            ex_out.pc     <= dec_in.pc;
            ex_out.opcode <= dec_in.opcode;
            ex_out.rd     <= dec_in.rd;
            ex_out.result <= result;
            ex_out.sdata  <= rd_data2;
        end
    end

endmodule

`default_nettype wire

// ==== design/diad_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "diad_macros.svh"

module diad_decode import diad_pkg::*; (
    input  wire logic   iw_clk,
    input  wire logic   iw_rst,
    input  wire fetch_t fetch_in,
    output decode_t     dec_out
);

    instr_t  ins;
    opcode_e op;
    data_t   imm_ext;

    assign ins = instr_t'(fetch_in.instr);

    // Unused encodings behave as NOP
    always_comb begin
        if (ins.opcode > OP_ST) begin
            op = OP_NOP;
        end
        else begin
            op = opcode_e'(ins.opcode);
        end
    end

    assign imm_ext = {{(`DIAD_DATA_W-`DIAD_IMM_W){ins.rs2_imm[`DIAD_IMM_W-1]}}, ins.rs2_imm};

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec_out.valid <= 1'b0;
        end
        else begin
            dec_out.valid  <= fetch_in.valid;
            dec_out.pc     <= fetch_in.pc;
            dec_out.opcode <= op;
            dec_out.rd     <= ins.rd;
            dec_out.rs1    <= ins.rs1;
            dec_out.rs2    <= ins.rs2_imm[`DIAD_REG_W-1:0];
            dec_out.imm    <= imm_ext;
        end
    end

endmodule

`default_nettype wire

// ==== design/diad_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module diad_fetch import diad_pkg::*; (
    input  wire logic  iw_clk,
    input  wire logic  iw_rst,
    input  wire logic  run,
    output addr_t      fetch_addr,
    input  wire data_t fetch_data,
    output fetch_t     fetch_out
);

    addr_t pc;
    logic  pend_valid; // An address went out last cycle
    addr_t pend_pc;

    assign fetch_addr = pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc         <= '0;
            pend_valid <= 1'b0;
        end
        else begin
            pend_valid <= run;
            if (run) begin
                pc <= pc + addr_t'(1);
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        pend_pc <= pc;
    end

    // Memory data arrives one cycle after the address, pair it with its pc
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            fetch_out.valid <= 1'b0;
        end
        else begin
            fetch_out.valid <= pend_valid;
            fetch_out.pc    <= pend_pc;
            fetch_out.instr <= fetch_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/diad_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "diad_macros.svh"

module diad_regfile import diad_pkg::*; (
    input  wire logic     iw_clk,
    input  wire logic     iw_rst,
    input  wire reg_idx_t rd_addr1,
    input  wire reg_idx_t rd_addr2,
    output data_t         rd_data1,
    output data_t         rd_data2,
    input  wire logic     wr_en,
    input  wire reg_idx_t wr_addr,
    input  wire data_t    wr_data
);

    data_t regs [`DIAD_NUM_REGS];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `DIAD_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_addr != '0) begin // r0 never leaves zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

// ==== design/diad_mem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "diad_macros.svh"

module diad_mem import diad_pkg::*; (
    input  wire logic  iw_clk,
    input  wire addr_t fetch_addr,
    output data_t      fetch_data,
    input  wire addr_t data_addr,
    input  wire logic  data_we,
    input  wire data_t data_wdata,
    output data_t      data_rdata,
    input  wire logic  load_we,
    input  wire addr_t load_addr,
    input  wire data_t load_data
);

    data_t mem [`DIAD_MEM_DEPTH];

    // Program loading takes the single write port ahead of stores
    always_ff @(posedge iw_clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
        else if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
    end

    always_ff @(posedge iw_clk) begin
        fetch_data <= mem[fetch_addr];
    end

    // Reads return the word held before a write on the same edge
    always_ff @(posedge iw_clk) begin
        data_rdata <= mem[data_addr];
    end

endmodule

`default_nettype wire

// ==== design/diad_pkg.sv ====
`default_nettype none
`include "diad_macros.svh"

package diad_pkg;

    typedef logic [`DIAD_DATA_W-1:0] data_t;
    typedef logic [`DIAD_ADDR_W-1:0] addr_t;
    typedef logic [`DIAD_REG_W-1:0]  reg_idx_t;
    typedef logic [`DIAD_IMM_W-1:0]  imm_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SHL  = 4'd6,
        OP_SHR  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LD   = 4'd9,
        OP_ST   = 4'd10
    } opcode_e;

    // Raw encoding, opcode in the top nibble
    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        imm_t       rs2_imm; // rs2 sits in the low bits
    } instr_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        data_t instr;
    } fetch_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
    } decode_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        opcode_e  opcode;
        reg_idx_t rd;
        data_t    result; // ALU value or effective address
        data_t    sdata;
    } exec_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        opcode_e  opcode;
        reg_idx_t rd;
        data_t    result;
    } mem_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        opcode_e  opcode;
        reg_idx_t rd;
        logic     we;
        data_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/diad_macros.svh ====
`ifndef DIAD_MACROS_SVH
`define DIAD_MACROS_SVH

// Data and instruction words share one width
`define DIAD_DATA_W 16

// Word address into the shared memory
`define DIAD_ADDR_W 8

// Register index and register count
`define DIAD_REG_W 3
`define DIAD_NUM_REGS 8

// Raw immediate field of the instruction
`define DIAD_IMM_W 6

// Words in the unified instruction and data memory
`define DIAD_MEM_DEPTH 256

`endif
